// File: src/md_defines.svh
// Console main-bus constants
// Address map, memory sizes and the open-bus reset word
`ifndef MD_DEFINES_SVH
`define MD_DEFINES_SVH

// Open-bus word after reset, a 68K NOP
`define MD_OPEN_BUS_RESET 16'h4E71

// Memory sizes as address widths
`define MD_WRAM_AW 15
`define MD_ZRAM_AW 13

// Mapper
`define MD_BANK_COUNT 8
// 2 MB, as a ROM word address
`define MD_MAPPER_MIN_ROM 24'h100000

// Region bases, byte addresses
`define MD_ZRAM_BASE 24'hA00000
`define MD_CTRL_BUSREQ 24'hA11100
`define MD_CTRL_RESET 24'hA11200
`define MD_BANK_BASE 24'hA13000
`define MD_WRAM_BASE 24'hE00000

`endif

// File: src/md_bus_pkg.sv
// Main-bus types
// Bus words and addresses, ROM address, bank number, decode and FSM enums
package md_bus_pkg;

	// 68K word address, byte lane chosen by sel
	typedef logic [23:1] mbus_addr_t;
	typedef logic [15:0] mbus_data_t;
	typedef logic [7:0]  byte_t;

	// Word address into a ROM of up to 32 MB
	typedef logic [24:1] rom_addr_t;
	typedef logic [4:0]  bank_t;

	typedef enum logic [2:0] {
		TGT_ROM,
		TGT_ZRAM,
		TGT_CTRL,
		TGT_BANK,
		TGT_WRAM,
		TGT_NONE
	} mbus_target_t;

	typedef enum logic [2:0] {
		IDLE,
		SELECT,
		MEM_READ,
		ROM_WAIT,
		FINISH
	} mbus_state_t;

endpackage

// File: src/sync_ram.sv
// Single-port synchronous RAM
// One-cycle read, one write enable per byte of the word type
`timescale 1ns/100ps

module sync_ram #(
	parameter type word_t = logic [7:0],
	parameter int  AW     = 8,
	localparam int NB     = $bits(word_t) / 8
) (
	input  logic          MCLK,
	input  logic [AW-1:0] addr,
	input  logic [NB-1:0] we,
	input  word_t         din,
	output word_t         q
);

	word_t mem [2**AW];

	always_ff @(posedge MCLK) begin
		// Lane 0 is the low byte
		for (int i = 0; i < NB; i++) begin
			if (we[i])
				mem[addr][i*8 +: 8] <= din[i*8 +: 8];
		end
		q <= mem[addr];
	end

endmodule

// File: src/rom_mapper.sv
// ROM bank mapper for cartridges above 2 MB
// Eight 512 KB bank registers at A130xx enabled by the first bank write
`timescale 1ns/100ps
`include "md_defines.svh"

module rom_mapper (
	input  logic                   MCLK,
	input  logic                   reset,
	input  md_bus_pkg::mbus_addr_t bus_adr,
	input  md_bus_pkg::bank_t      bus_data,
	input  logic                   bank_we,
	input  md_bus_pkg::rom_addr_t  rom_size,
	output md_bus_pkg::rom_addr_t  rom_adr
);
	import md_bus_pkg::*;

	localparam int IW = $clog2(`MD_BANK_COUNT);

	bank_t         bank [`MD_BANK_COUNT];
	logic          map_en;
	logic [IW-1:0] wr_idx;
	logic [IW-1:0] rd_idx;
	logic          bank_ok;

	assign wr_idx  = bus_adr[IW:1];
	// Each bank window is 512 KB of CPU space
	assign rd_idx  = bus_adr[18+IW:19];
	// Register 0 never takes a write
	assign bank_ok = bank_we && rom_size > `MD_MAPPER_MIN_ROM && wr_idx != '0;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			map_en <= 1'b0;
			for (int i = 0; i < `MD_BANK_COUNT; i++)
				bank[i] <= bank_t'(i);
		end else if (bank_ok) begin
			bank[wr_idx] <= bus_data;
			map_en       <= 1'b1;
		end
	end

	assign rom_adr = map_en ? {1'b0, bank[rd_idx], bus_adr[18:1]} : {1'b0, bus_adr};

	// The first 512 KB window always maps onto itself
	bank0_fixed: assert property (@(posedge MCLK) disable iff (reset)
		bus_adr[23:19] == '0 |-> rom_adr == {1'b0, bus_adr});

endmodule

// File: src/mbus_ctrl.sv
// Main-bus controller
// Decodes each CPU cycle against the address map, runs the cycle FSM,
// keeps the open-bus word and the sound-CPU bus request and reset
`timescale 1ns/100ps
`include "md_defines.svh"

module mbus_ctrl (
	input  logic                   MCLK,
	input  logic                   reset,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [1:0]             sel,
	input  md_bus_pkg::mbus_addr_t adr,
	input  md_bus_pkg::mbus_data_t dat_w,
	input  md_bus_pkg::rom_addr_t  rom_size,
	input  md_bus_pkg::mbus_data_t rom_dat,
	input  logic                   rom_ack,
	input  md_bus_pkg::mbus_data_t wram_q,
	input  md_bus_pkg::byte_t      zram_q,
	output md_bus_pkg::mbus_data_t dat_r,
	output logic                   ack,
	output logic                   rom_cyc,
	output logic                   rom_stb,
	output md_bus_pkg::mbus_addr_t bus_adr,
	output logic [1:0]             wram_we,
	output logic                   zram_we,
	output md_bus_pkg::byte_t      zram_din,
	output logic                   bank_we
);
	import md_bus_pkg::*;

	localparam logic [23:0] ZRAM_BASE   = `MD_ZRAM_BASE;
	localparam logic [23:0] CTRL_BUSREQ = `MD_CTRL_BUSREQ;
	localparam logic [23:0] CTRL_RESET  = `MD_CTRL_RESET;
	localparam logic [23:0] BANK_BASE   = `MD_BANK_BASE;
	localparam logic [23:0] WRAM_BASE   = `MD_WRAM_BASE;

	mbus_state_t  state;
	mbus_target_t tgt;
	logic         we_q;
	logic [1:0]   sel_q;
	mbus_data_t   dat_q;
	mbus_data_t   open_bus;
	logic         z80_busreq;
	logic         z80_run;
	logic         granted;
	logic         rom_area;
	logic         is_busreq;
	logic         ctrl_wr;
	logic         ctrl_bit;

	// ---------------------------------------------------------------------
	// Address decode of the latched request
	// ---------------------------------------------------------------------
	assign is_busreq = bus_adr == CTRL_BUSREQ[23:1];

	always_comb begin
		rom_area = bus_adr[23:22] == 2'b00;
		if (rom_area)
			tgt = ({1'b0, bus_adr} < rom_size) ? TGT_ROM : TGT_NONE;
		// A00000-A03FFF in 8 KB mirrors
		else if (bus_adr[23:14] == ZRAM_BASE[23:14])
			tgt = TGT_ZRAM;
		else if (is_busreq || bus_adr == CTRL_RESET[23:1])
			tgt = TGT_CTRL;
		else if (bus_adr[23:8] == BANK_BASE[23:8])
			tgt = TGT_BANK;
		else if (bus_adr[23:21] == WRAM_BASE[23:21])
			tgt = TGT_WRAM;
		else
			tgt = TGT_NONE;
	end

	// Write strobes all issue from SELECT
	assign wram_we  = (state == SELECT && tgt == TGT_WRAM && we_q) ? sel_q : 2'b00;
	assign zram_we  = state == SELECT && tgt == TGT_ZRAM && we_q && granted;
	assign bank_we  = state == SELECT && tgt == TGT_BANK && we_q;
	assign ctrl_wr  = state == SELECT && tgt == TGT_CTRL && we_q && sel_q[1];
	assign zram_din = sel_q[1] ? dat_q[15:8] : dat_q[7:0];

	// ---------------------------------------------------------------------
	// Sound-CPU control
	// ---------------------------------------------------------------------
	assign granted  = z80_busreq && z80_run;
	// Busreq word reads back "not granted", reset word "released"
	assign ctrl_bit = is_busreq ? ~granted : z80_run;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq <= 1'b0;
			z80_run    <= 1'b0;
		end else if (ctrl_wr) begin
			if (is_busreq)
				z80_busreq <= dat_q[8];
			else
				z80_run <= dat_q[8];
		end
	end

	// ---------------------------------------------------------------------
	// Cycle FSM
	// ---------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state    <= IDLE;
			ack      <= 1'b0;
			rom_cyc  <= 1'b0;
			rom_stb  <= 1'b0;
			open_bus <= `MD_OPEN_BUS_RESET;
		end else begin
			ack <= 1'b0;
			case (state)
			IDLE:
				if (cyc && stb)
					state <= SELECT;
			// ROM writes take the internal path and are dropped
			SELECT:
				state <= (tgt == TGT_ROM && !we_q) ? ROM_WAIT : MEM_READ;
			MEM_READ: begin
				if (tgt == TGT_WRAM && !we_q)
					open_bus <= wram_q;
				state <= FINISH;
			end
			ROM_WAIT:
				if (!rom_stb) begin
					rom_cyc <= 1'b1;
					rom_stb <= 1'b1;
				end else if (rom_ack) begin
					rom_cyc  <= 1'b0;
					rom_stb  <= 1'b0;
					open_bus <= rom_dat;
					state    <= FINISH;
				end
			FINISH: begin
				ack   <= 1'b1;
				state <= IDLE;
			end
			default:
				state <= IDLE;
			endcase
		end
	end

	// Request latch and read data
	always_ff @(posedge MCLK) begin
		if (state == IDLE && cyc && stb) begin
			bus_adr <= adr;
			we_q    <= we;
			sel_q   <= sel;
			dat_q   <= dat_w;
		end
		if (state == MEM_READ) begin
			case (tgt)
			TGT_WRAM: dat_r <= wram_q;
			TGT_ZRAM: dat_r <= granted ? {zram_q, zram_q} : 16'hFFFF;
			TGT_CTRL: dat_r <= {open_bus[15:9], ctrl_bit, open_bus[7:0]};
			// Past the end of the ROM reads as zero
			TGT_NONE: dat_r <= rom_area ? 16'h0000 : open_bus;
			default:  dat_r <= open_bus;
			endcase
		end else if (state == ROM_WAIT && rom_stb && rom_ack) begin
			dat_r <= rom_dat;
		end
	end

	// ---------------------------------------------------------------------
	// Protocol checks
	// ---------------------------------------------------------------------
	ack_in_cycle: assert property (@(posedge MCLK) disable iff (reset)
		ack |-> $past(cyc && stb));
	rom_stb_in_wait: assert property (@(posedge MCLK) disable iff (reset)
		rom_stb |-> state == ROM_WAIT);
	ack_single: assert property (@(posedge MCLK) disable iff (reset)
		ack |=> !ack);

endmodule

// File: src/md_bus_top.sv
// Console main-bus top level
// CPU-side Wishbone slave, cartridge ROM Wishbone master,
// bus controller, ROM mapper, work RAM and sound RAM
`timescale 1ns/100ps
`include "md_defines.svh"

module md_bus_top (
	input  logic                   MCLK,
	input  logic                   reset,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [1:0]             sel,
	input  md_bus_pkg::mbus_addr_t adr,
	input  md_bus_pkg::mbus_data_t dat_w,
	output md_bus_pkg::mbus_data_t dat_r,
	output logic                   ack,
	input  md_bus_pkg::rom_addr_t  rom_size,
	output logic                   rom_cyc,
	output logic                   rom_stb,
	output md_bus_pkg::rom_addr_t  rom_adr,
	input  md_bus_pkg::mbus_data_t rom_dat,
	input  logic                   rom_ack
);
	import md_bus_pkg::*;

	mbus_addr_t bus_adr;
	logic [1:0] wram_we;
	logic       zram_we;
	logic       bank_we;
	byte_t      zram_din;
	byte_t      zram_q;
	mbus_data_t wram_q;

	mbus_ctrl ctrl (
		.MCLK(MCLK), .reset(reset),
		.cyc(cyc), .stb(stb), .we(we), .sel(sel), .adr(adr), .dat_w(dat_w),
		.rom_size(rom_size), .rom_dat(rom_dat), .rom_ack(rom_ack),
		.wram_q(wram_q), .zram_q(zram_q),
		.dat_r(dat_r), .ack(ack), .rom_cyc(rom_cyc), .rom_stb(rom_stb),
		.bus_adr(bus_adr), .wram_we(wram_we), .zram_we(zram_we),
		.zram_din(zram_din), .bank_we(bank_we)
	);

	// Bank number comes from the low data bits
	rom_mapper mapper (
		.MCLK(MCLK), .reset(reset),
		.bus_adr(bus_adr), .bus_data(dat_w[4:0]), .bank_we(bank_we),
		.rom_size(rom_size), .rom_adr(rom_adr)
	);

	// 64 KB work RAM, mirrored over E00000-FFFFFF
	sync_ram #(.word_t(mbus_data_t), .AW(`MD_WRAM_AW)) work_ram (
		.MCLK(MCLK), .addr(bus_adr[`MD_WRAM_AW:1]), .we(wram_we),
		.din(dat_w), .q(wram_q)
	);

	// 8 KB sound RAM, upper lane selects the even byte
	sync_ram #(.word_t(byte_t), .AW(`MD_ZRAM_AW)) sound_ram (
		.MCLK(MCLK), .addr({bus_adr[`MD_ZRAM_AW-1:1], ~sel[1]}), .we(zram_we),
		.din(zram_din), .q(zram_q)
	);

endmodule

// File: test/md_bus_model.svh
// Reference model of the console main bus
// Work RAM, sound RAM, bank table, sound-CPU grant and open-bus word
`ifndef MD_BUS_MODEL_SVH
`define MD_BUS_MODEL_SVH

localparam logic [23:0] M_ZRAM_BASE   = `MD_ZRAM_BASE;
localparam logic [23:0] M_CTRL_BUSREQ = `MD_CTRL_BUSREQ;
localparam logic [23:0] M_CTRL_RESET  = `MD_CTRL_RESET;
localparam logic [23:0] M_BANK_BASE   = `MD_BANK_BASE;
localparam logic [23:0] M_WRAM_BASE   = `MD_WRAM_BASE;

mbus_data_t wram_m [2**`MD_WRAM_AW];
byte_t      zram_m [2**`MD_ZRAM_AW];
bank_t      banks_m [`MD_BANK_COUNT];
logic       map_en_m;
logic       busreq_m;
logic       run_m;
mbus_data_t open_bus_m;

// Registers only, memories keep their contents over reset
function automatic void reset_model();
	for (int i = 0; i < `MD_BANK_COUNT; i++)
		banks_m[i] = bank_t'(i);
	map_en_m   = 1'b0;
	busreq_m   = 1'b0;
	run_m      = 1'b0;
	open_bus_m = `MD_OPEN_BUS_RESET;
endfunction

function automatic mbus_data_t predict_read(input mbus_addr_t a, input logic [1:0] s,
	output bit is_rom, output rom_addr_t radr);
	logic [23:0] a24;
	mbus_data_t  d;
	byte_t       b;
	logic        grant;
	a24    = {a, 1'b0};
	is_rom = 1'b0;
	radr   = '0;
	grant  = busreq_m && run_m;
	if (a24[23:22] == 2'b00) begin
		if ({1'b0, a} < rom_size) begin
			is_rom     = 1'b1;
			radr       = map_en_m ? {1'b0, banks_m[a[21:19]], a[18:1]} : {1'b0, a};
			d          = radr[16:1] ^ 16'hA5C3;
			open_bus_m = d;
		end else begin
			d = 16'h0000;
		end
	end else if (a24[23:14] == M_ZRAM_BASE[23:14]) begin
		b = zram_m[{a[12:1], ~s[1]}];
		d = grant ? {b, b} : 16'hFFFF;
	end else if (a24 == M_CTRL_BUSREQ) begin
		d = {open_bus_m[15:9], ~grant, open_bus_m[7:0]};
	end else if (a24 == M_CTRL_RESET) begin
		d = {open_bus_m[15:9], run_m, open_bus_m[7:0]};
	end else if (a24[23:8] == M_BANK_BASE[23:8]) begin
		d = open_bus_m;
	end else if (a24[23:21] == M_WRAM_BASE[23:21]) begin
		d          = wram_m[a[15:1]];
		open_bus_m = d;
	end else begin
		d = open_bus_m;
	end
	return d;
endfunction

function automatic void apply_write(input mbus_addr_t a, input logic [1:0] s,
	input mbus_data_t d);
	logic [23:0] a24;
	a24 = {a, 1'b0};
	if (a24[23:22] == 2'b00) begin
		// ROM area ignores writes
	end else if (a24[23:14] == M_ZRAM_BASE[23:14]) begin
		if (busreq_m && run_m)
			zram_m[{a[12:1], ~s[1]}] = s[1] ? d[15:8] : d[7:0];
	end else if (a24 == M_CTRL_BUSREQ) begin
		if (s[1])
			busreq_m = d[8];
	end else if (a24 == M_CTRL_RESET) begin
		if (s[1])
			run_m = d[8];
	end else if (a24[23:8] == M_BANK_BASE[23:8]) begin
		if (rom_size > `MD_MAPPER_MIN_ROM && a[3:1] != 3'd0) begin
			banks_m[a[3:1]] = d[4:0];
			map_en_m        = 1'b1;
		end
	end else if (a24[23:21] == M_WRAM_BASE[23:21]) begin
		if (s[1])
			wram_m[a[15:1]][15:8] = d[15:8];
		if (s[0])
			wram_m[a[15:1]][7:0] = d[7:0];
	end
endfunction

`endif

// File: test/tb_md_bus.sv
// Testbench for the console main bus
// Random cycles against the included model and a ROM responder
`timescale 1ns/100ps
`include "md_defines.svh"

module tb_md_bus;
	import md_bus_pkg::*;

	localparam int         ACK_TIMEOUT = 200;
	localparam mbus_addr_t UNMAPPED    = 23'h400000;
	localparam mbus_addr_t BUSREQ_W    = mbus_addr_t'(`MD_CTRL_BUSREQ >> 1);
	localparam mbus_addr_t RESET_W     = mbus_addr_t'(`MD_CTRL_RESET >> 1);
	localparam mbus_addr_t BANK_W      = mbus_addr_t'(`MD_BANK_BASE >> 1);
	localparam mbus_addr_t ZRAM_W      = mbus_addr_t'(`MD_ZRAM_BASE >> 1);

	logic       MCLK;
	logic       reset;
	logic       cyc;
	logic       stb;
	logic       we;
	logic [1:0] sel;
	mbus_addr_t adr;
	mbus_data_t dat_w;
	mbus_data_t dat_r;
	logic       ack;
	rom_addr_t  rom_size;
	logic       rom_cyc;
	logic       rom_stb;
	rom_addr_t  rom_adr;
	mbus_data_t rom_dat;
	logic       rom_ack;
	int         data_errs = 0;
	int         adr_errs = 0;
	int         proto_errs = 0;
	int         wr_idx [16];

	`include "md_bus_model.svh"

	md_bus_top uut (
		.MCLK(MCLK), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .sel(sel),
		.adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .rom_size(rom_size),
		.rom_cyc(rom_cyc), .rom_stb(rom_stb), .rom_adr(rom_adr),
		.rom_dat(rom_dat), .rom_ack(rom_ack)
	);

	initial begin
		MCLK = 1'b0;
		forever #50 MCLK = ~MCLK;
	end

	// ---------------------------------------------------------------------
	// Cartridge ROM answering after 0 to 5 cycles
	// ---------------------------------------------------------------------
	initial begin : rom_responder
		int delay;
		rom_ack = 1'b0;
		rom_dat = '0;
		forever begin
			@(negedge MCLK);
			if (rom_stb && !rom_ack) begin
				delay = $urandom % 6;
				repeat (delay) @(negedge MCLK);
				rom_dat = rom_adr[16:1] ^ 16'hA5C3;
				rom_ack = 1'b1;
				@(negedge MCLK);
				rom_ack = 1'b0;
			end
		end
	end

	task automatic finish_run();
		$display("errors: data %0d, rom address %0d, protocol %0d",
			data_errs, adr_errs, proto_errs);
		if (data_errs + adr_errs + proto_errs == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_data(input string name, input mbus_data_t got,
		input mbus_data_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			data_errs++;
		end
	endtask

	task automatic check_rom_adr(input string name, input rom_addr_t got,
		input rom_addr_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			adr_errs++;
		end
	endtask

	// One Wishbone cycle with latency counted from the sampling edge
	task automatic bus_cycle(input logic w, input logic [1:0] s, input mbus_addr_t a,
		input mbus_data_t d, output mbus_data_t q, output int lat,
		output logic rom_seen, output rom_addr_t seen_adr);
		int n;
		n        = 0;
		rom_seen = 1'b0;
		seen_adr = '0;
		@(negedge MCLK);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = w;
		sel   = s;
		adr   = a;
		dat_w = d;
		do begin
			@(negedge MCLK);
			n++;
			if (rom_stb && !rom_seen) begin
				rom_seen = 1'b1;
				seen_adr = rom_adr;
			end
			if (rom_cyc !== rom_stb) begin
				$display("rom_cyc and rom_stb differ during the cycle at %h", {a, 1'b0});
				proto_errs++;
			end
		end while (!ack && n <= ACK_TIMEOUT);
		if (!ack) begin
			$display("Timeout waiting for ack at byte address %h", {a, 1'b0});
			proto_errs++;
			finish_run();
		end else begin
			q   = dat_r;
			lat = n - 1;
			cyc = 1'b0;
			stb = 1'b0;
			we  = 1'b0;
		end
	endtask

	task automatic read_and_compare(input mbus_addr_t a, input logic [1:0] s);
		mbus_data_t q;
		mbus_data_t exp;
		int         lat;
		logic       seen;
		rom_addr_t  sa;
		bit         is_rom;
		rom_addr_t  radr;
		bus_cycle(1'b0, s, a, '0, q, lat, seen, sa);
		exp = predict_read(a, s, is_rom, radr);
		check_data("dat_r", q, exp);
		if (is_rom) begin
			if (!seen) begin
				$display("No ROM cycle for the read at %h", {a, 1'b0});
				proto_errs++;
			end else begin
				check_rom_adr("rom_adr", sa, radr);
			end
		end else begin
			if (seen) begin
				$display("Unexpected ROM cycle for the read at %h", {a, 1'b0});
				proto_errs++;
			end
			if (lat != 3) begin
				$display("Read at %h acked after %0d cycles, not 3", {a, 1'b0}, lat);
				proto_errs++;
			end
		end
	endtask

	task automatic write_and_record(input mbus_addr_t a, input logic [1:0] s,
		input mbus_data_t d);
		mbus_data_t q;
		int         lat;
		logic       seen;
		rom_addr_t  sa;
		bus_cycle(1'b1, s, a, d, q, lat, seen, sa);
		apply_write(a, s, d);
		if (seen || lat != 3) begin
			$display("Write at %h took %0d cycles or started a ROM cycle", {a, 1'b0}, lat);
			proto_errs++;
		end
	endtask

	// ---------------------------------------------------------------------
	// Stimulus
	// ---------------------------------------------------------------------
	initial begin
		mbus_addr_t a;
		logic [1:0] s;
		mbus_data_t d;
		int         i;
		void'($urandom(32'h2bdb));
		reset    = 1'b1;
		cyc      = 1'b0;
		stb      = 1'b0;
		we       = 1'b0;
		sel      = 2'b00;
		adr      = '0;
		dat_w    = '0;
		rom_size = 24'h080000;
		reset_model();
		repeat (10) @(negedge MCLK);
		reset = 1'b0;

		// Open bus after reset and work RAM through mirrors
		read_and_compare(UNMAPPED, 2'b11);
		for (int k = 0; k < 16; k++) begin
			wr_idx[k] = $urandom % 32768;
			write_and_record({3'b111, 5'($urandom), 15'(wr_idx[k])}, 2'b11, 16'($urandom));
		end
		for (int k = 0; k < 48; k++) begin
			i = $urandom % 16;
			a = {3'b111, 5'($urandom), 15'(wr_idx[i])};
			if ($urandom % 3 == 0) begin
				read_and_compare(a, 2'b11);
				read_and_compare(UNMAPPED, 2'b11);
			end else begin
				s = 2'($urandom % 3 + 1);
				write_and_record(a, s, 16'($urandom));
			end
		end

		// 1 MB ROM with reads past the end and ignored bank writes
		for (int k = 0; k < 24; k++) begin
			read_and_compare(23'($urandom % 24'h080000), 2'b11);
			read_and_compare(UNMAPPED, 2'b11);
		end
		for (int k = 0; k < 8; k++) begin
			read_and_compare(23'(24'h080000 + $urandom % 24'h180000), 2'b11);
			read_and_compare(UNMAPPED, 2'b11);
		end
		// Every register gets a bank number other than its own
		for (int k = 1; k < 8; k++)
			write_and_record(BANK_W + 23'(k), 2'b11,
				{11'($urandom), 5'(k) ^ 5'h10});
		for (int k = 0; k < 8; k++)
			read_and_compare(23'($urandom % 24'h080000), 2'b11);

		// 4 MB ROM with the mapper
		@(negedge MCLK);
		reset    = 1'b1;
		rom_size = 24'h200000;
		repeat (10) @(negedge MCLK);
		reset = 1'b0;
		reset_model();
		for (int k = 0; k < 12; k++)
			write_and_record(BANK_W + 23'($urandom % 8), 2'b11, 16'($urandom));
		for (int k = 0; k < 24; k++)
			read_and_compare(23'($urandom % 24'h200000), 2'b11);

		// Sound RAM before and after the grant
		for (int k = 0; k < 4; k++) begin
			a = ZRAM_W + 23'(13'($urandom));
			s = ($urandom % 2) ? 2'b10 : 2'b01;
			read_and_compare(a, s);
			write_and_record(a, s, 16'($urandom));
			read_and_compare(a, s);
		end
		read_and_compare(BUSREQ_W, 2'b11);
		read_and_compare(RESET_W, 2'b11);
		write_and_record(BUSREQ_W, 2'b10, 16'h0100);
		read_and_compare(BUSREQ_W, 2'b11);
		read_and_compare(RESET_W, 2'b11);
		write_and_record(RESET_W, 2'b10, 16'h0100);
		read_and_compare(BUSREQ_W, 2'b11);
		read_and_compare(RESET_W, 2'b11);
		for (int k = 0; k < 16; k++) begin
			a = ZRAM_W + 23'(13'($urandom));
			s = ($urandom % 2) ? 2'b10 : 2'b01;
			d = 16'($urandom);
			write_and_record(a, s, d);
			read_and_compare(a, s);
			read_and_compare(UNMAPPED, 2'b11);
		end

		// Released bus loses the write, the old byte returns after the regrant
		write_and_record(BUSREQ_W, 2'b10, 16'h0000);
		read_and_compare(BUSREQ_W, 2'b11);
		read_and_compare(a, s);
		write_and_record(a, s, ~d);
		write_and_record(BUSREQ_W, 2'b10, 16'h0100);
		read_and_compare(a, s);

		finish_run();
	end

endmodule

// File: filelist.f
+incdir+src
+incdir+test
src/md_bus_pkg.sv
src/sync_ram.sv
src/rom_mapper.sv
src/mbus_ctrl.sv
src/md_bus_top.sv
test/tb_md_bus.sv

// File: Makefile
TOP = tb_md_bus

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f src/*.sv src/*.svh test/*.sv test/*.svh
	verilator --binary --timing -f filelist.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
